/* include/nes_host_defines.svh */
// Shared constants for the NES host glue
// Memory map of the cartridge loader, iNES header layout and controller port sizes
`ifndef NES_HOST_DEFINES_SVH
`define NES_HOST_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// Cartridge memory map
//////////////////////////////////////////////////////////////////////

`define NES_ADDR_W          22
`define NES_CHR_BASE        22'h200000 // CHR region starts at bit 21
`define NES_PRG_PAGE_SHIFT  14         // 16 KB PRG pages
`define NES_CHR_PAGE_SHIFT  13         // 8 KB CHR pages

//////////////////////////////////////////////////////////////////////
// iNES header
//////////////////////////////////////////////////////////////////////

`define NES_HDR_BYTES       16
`define NES_MAGIC_0         8'h4E // N
`define NES_MAGIC_1         8'h45 // E
`define NES_MAGIC_2         8'h53 // S
`define NES_MAGIC_3         8'h1A

//////////////////////////////////////////////////////////////////////
// Controller ports
//////////////////////////////////////////////////////////////////////

`define NES_PAD_BITS        8
`define NES_PORT_BITS       24
`define NES_NUM_PORTS       2
`define NES_NUM_JOY         4     // Host joysticks A to D
`define NES_TAP_SIG_0       8'h08 // Multitap signature, port 0
`define NES_TAP_SIG_1       8'h04 // Multitap signature, port 1

`endif

/* hw/nes_host_pkg.sv */
// Types shared by the NES host loader and controller ports
// Referenced by scoped name from the modules that need them
`default_nettype none

`include "nes_host_defines.svh"

package nes_host_pkg;

	// Loader FSM
	typedef enum logic [2:0] {
		LOAD_HEADER,
		LOAD_PRG,
		LOAD_CHR,
		LOAD_ERROR,
		LOAD_DONE
	} loader_state_e;

	// One byte write into cartridge memory
	typedef struct packed {
		logic [`NES_ADDR_W-1:0] addr;
		logic [7:0]             data;
	} mem_write_t;

	// Mapper flags word handed to the core
	typedef struct packed {
		logic [5:0] spare;
		logic       has_saves;   // Battery backed RAM
		logic [7:0] submapper;   // iNES 2.0 only
		logic       four_screen;
		logic       chr_ram;
		logic       mirroring;
		logic [2:0] chr_size;    // Log2 style size code
		logic [2:0] prg_size;
		logic [7:0] mapper;
	} mapper_flags_t;

	typedef struct packed {
		logic swap;     // Exchange players A and B
		logic multitap; // Four player adapter
	} pad_options_t;

	// Parallel load words, one per port
	typedef struct packed {
		logic [`NES_NUM_PORTS-1:0][`NES_PORT_BITS-1:0] word;
	} pad_load_t;

endpackage

`default_nettype wire

/* hw/ines_header_decoder.sv */
// Decodes a captured iNES header into the magic check and the mapper flags
// Purely combinational, driven from the loader's header array
`timescale 1ns/1ps
`default_nettype none

`include "nes_host_defines.svh"

module ines_header_decoder (
	input  wire logic [`NES_HDR_BYTES-1:0][7:0] header,
	input  wire logic                           invert_mirroring,
	output logic                                header_ok,
	output nes_host_pkg::mapper_flags_t         flags
);

	logic magic_ok;
	logic has_trainer;
	logic is_nes20;
	logic is_dirty;
	logic [7:0] prg_pages;
	logic [7:0] chr_pages;

	// Page count to size code, rounded up to the next power of two
	function automatic logic [2:0] size_code(input logic [7:0] pages);
		logic [2:0] code;
		if (pages <= 8'd1)
			code = 3'd0;
		else if (pages <= 8'd2)
			code = 3'd1;
		else if (pages <= 8'd4)
			code = 3'd2;
		else if (pages <= 8'd8)
			code = 3'd3;
		else if (pages <= 8'd16)
			code = 3'd4;
		else if (pages <= 8'd32)
			code = 3'd5;
		else if (pages <= 8'd64)
			code = 3'd6;
		else
			code = 3'd7;
		return code;
	endfunction

	assign prg_pages = header[4];
	assign chr_pages = header[5];  // Zero means CHR RAM

	assign magic_ok = header[0] == `NES_MAGIC_0 && header[1] == `NES_MAGIC_1 &&
	                  header[2] == `NES_MAGIC_2 && header[3] == `NES_MAGIC_3;
	assign has_trainer = header[6][2];  // Trainers are not supported
	assign header_ok   = magic_ok && !has_trainer;

	assign is_nes20 = header[7][3:2] == 2'b10;

	// Old dumpers left junk in the tail of 1.0 headers
	assign is_dirty = !is_nes20 && (header[9][7:1] != 7'd0 || header[15:10] != '0);

	always_comb begin
		flags             = '0;
		flags.has_saves   = header[6][1];
		flags.submapper   = is_nes20 ? header[8] : 8'h00;
		flags.four_screen = header[6][3];
		flags.chr_ram     = chr_pages == 8'd0;
		flags.mirroring   = header[6][0] ^ invert_mirroring;
		flags.chr_size    = size_code(chr_pages);
		flags.prg_size    = size_code(prg_pages);
		flags.mapper      = {is_dirty ? 4'h0 : header[7][7:4], header[6][7:4]};
	end

endmodule

`default_nettype wire

/* hw/rom_loader.sv */
// Cartridge image loader for iNES files
// Captures the 16 byte header, then streams PRG and CHR bytes into memory
// Restarts on every rising edge of downloading
`timescale 1ns/1ps
`default_nettype none

`include "nes_host_defines.svh"

module rom_loader (
	input  wire logic                   clk,
	input  wire logic                   reset_nes,
	input  wire logic                   downloading,
	input  wire logic                   byte_valid,
	input  wire logic                   invert_mirroring,
	input  wire logic [7:0]             byte_data,
	output logic                        mem_we,
	output nes_host_pkg::mem_write_t    mem_write,
	output logic                        busy,
	output logic                        done,
	output logic                        error,
	output nes_host_pkg::mapper_flags_t mapper_flags
);

	localparam int CTR_W = $clog2(`NES_HDR_BYTES);

	nes_host_pkg::loader_state_e state;

	logic [CTR_W-1:0]               hdr_ctr;
	logic [`NES_HDR_BYTES-1:0][7:0] header;
	logic [`NES_ADDR_W-1:0]         bytes_left;
	logic [`NES_ADDR_W-1:0]         addr;
	logic [`NES_ADDR_W-1:0]         prg_bytes;
	logic [`NES_ADDR_W-1:0]         chr_bytes;
	logic                           downloading_d;
	logic                           restart;
	logic                           header_ok;
	logic                           last_hdr_byte;
	logic                           data_phase;

	ines_header_decoder u_decoder (
		.header           (header),
		.invert_mirroring (invert_mirroring),
		.header_ok        (header_ok),
		.flags            (mapper_flags)
	);

	assign restart       = downloading && !downloading_d;
	assign last_hdr_byte = byte_valid && hdr_ctr == CTR_W'(`NES_HDR_BYTES - 1);

	assign prg_bytes = `NES_ADDR_W'(header[4]) << `NES_PRG_PAGE_SHIFT;
	assign chr_bytes = `NES_ADDR_W'(header[5]) << `NES_CHR_PAGE_SHIFT;

	// Writes only while a region still has bytes to go
	assign data_phase = (state == nes_host_pkg::LOAD_PRG || state == nes_host_pkg::LOAD_CHR) &&
	                    bytes_left != '0;
	assign mem_we     = data_phase && byte_valid;

	assign mem_write.addr = addr;
	assign mem_write.data = byte_data;

	//////////////////////////////////////////////////////////////////////
	// Control FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			state         <= nes_host_pkg::LOAD_HEADER;
			hdr_ctr       <= '0;
			bytes_left    <= '0;
			busy          <= 1'b0;
			done          <= 1'b0;
			error         <= 1'b0;
			downloading_d <= 1'b0;
		end else begin
			downloading_d <= downloading;
			if (restart) begin
				state      <= nes_host_pkg::LOAD_HEADER;
				hdr_ctr    <= '0;
				bytes_left <= '0;
				busy       <= 1'b0;
				done       <= 1'b0;
				error      <= 1'b0;
			end else begin
				case (state)
					nes_host_pkg::LOAD_HEADER: begin
						if (byte_valid)
							hdr_ctr <= hdr_ctr + 1'b1;
						if (last_hdr_byte) begin
							if (header_ok) begin
								state      <= nes_host_pkg::LOAD_PRG;
								bytes_left <= prg_bytes;
								busy       <= 1'b1;
							end else begin
								state <= nes_host_pkg::LOAD_ERROR;
							end
						end
					end
					nes_host_pkg::LOAD_PRG: begin
						if (bytes_left != '0) begin
							if (byte_valid)
								bytes_left <= bytes_left - 1'b1;
						end else if (header[5] == 8'd0) begin  // CHR RAM, nothing to load
							state <= nes_host_pkg::LOAD_DONE;
							done  <= 1'b1;
							busy  <= 1'b0;
						end else begin
							state      <= nes_host_pkg::LOAD_CHR;
							bytes_left <= chr_bytes;
						end
					end
					nes_host_pkg::LOAD_CHR: begin
						if (bytes_left != '0) begin
							if (byte_valid)
								bytes_left <= bytes_left - 1'b1;
						end else begin
							state <= nes_host_pkg::LOAD_DONE;
							done  <= 1'b1;
							busy  <= 1'b0;
						end
					end
					nes_host_pkg::LOAD_ERROR: begin
						done  <= 1'b1;
						error <= 1'b1;
						busy  <= 1'b0;
					end
					default: ;  // LOAD_DONE holds, later bytes ignored
				endcase
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Header capture and write address
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (state == nes_host_pkg::LOAD_HEADER && byte_valid && !restart)
			header[hdr_ctr] <= byte_data;

		if (mem_we)
			addr <= addr + 1'b1;
		else if (state == nes_host_pkg::LOAD_HEADER)
			addr <= '0;                 // PRG starts at zero
		else if (state == nes_host_pkg::LOAD_PRG && bytes_left == '0)
			addr <= `NES_CHR_BASE;
	end

endmodule

`default_nettype wire

/* hw/pad_port_mapper.sv */
// Builds the parallel load word of each controller port from the host joysticks
// Handles button reordering, player swap and the four player multitap
`timescale 1ns/1ps
`default_nettype none

`include "nes_host_defines.svh"

module pad_port_mapper (
	input  wire logic [`NES_NUM_JOY-1:0][`NES_PAD_BITS-1:0] joy,
	input  nes_host_pkg::pad_options_t                      pad_opts,
	output nes_host_pkg::pad_load_t                         load
);

	logic [`NES_NUM_JOY-1:0][`NES_PAD_BITS-1:0] nes_joy;

	// Host order R L D U A B Sel St to NES shift order A B Sel St U D L R
	function automatic logic [`NES_PAD_BITS-1:0] to_nes_order(
		input logic [`NES_PAD_BITS-1:0] host
	);
		return {host[0], host[1], host[2], host[3], host[7], host[6], host[5], host[4]};
	endfunction

	always_comb begin
		for (int j = 0; j < `NES_NUM_JOY; j++)
			nes_joy[j] = to_nes_order(joy[j]);
	end

	always_comb begin
		logic [7:0] sig;
		int         main_idx;
		for (int p = 0; p < `NES_NUM_PORTS; p++) begin
			main_idx = pad_opts.swap ? (p ^ 1) : p;
			sig      = (p == 0) ? `NES_TAP_SIG_0 : `NES_TAP_SIG_1;
			if (pad_opts.multitap)
				load.word[p] = {sig, nes_joy[p + 2], nes_joy[main_idx]};  // C or D in the middle
			else
				load.word[p] = {16'hFFFF, nes_joy[main_idx]};
		end
	end

endmodule

`default_nettype wire

/* hw/pad_port_shifter.sv */
// Serial shift register of one console controller port
// Strobe reloads it, each falling port clock shifts one bit out
`timescale 1ns/1ps
`default_nettype none

`include "nes_host_defines.svh"

module pad_port_shifter (
	input  wire logic                      clk,
	input  wire logic                      reset_nes,
	input  wire logic                      strobe,
	input  wire logic                      port_clock,
	input  wire logic [`NES_PORT_BITS-1:0] load_word,
	output logic                           serial_out
);

	logic [`NES_PORT_BITS-1:0] shift_q;
	logic                      port_clock_d;
	logic                      clock_fall;

	assign clock_fall = port_clock_d && !port_clock;

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			shift_q      <= '0;
			port_clock_d <= 1'b0;
		end else begin
			port_clock_d <= port_clock;
			if (strobe)
				shift_q <= load_word;                                      // Latch buttons
			else if (clock_fall)
				shift_q <= {1'b0, shift_q[`NES_PORT_BITS-1:1]};            // Zero fills from the top
		end
	end

	assign serial_out = shift_q[0];

endmodule

`default_nettype wire

/* hw/nes_host.sv */
// Top level of the NES host glue
// Cartridge image loader plus the two serial controller ports
`timescale 1ns/1ps
`default_nettype none

`include "nes_host_defines.svh"

module nes_host (
	input  wire logic                                   clk,
	input  wire logic                                   reset_nes,
	// Image stream
	input  wire logic                                   downloading,
	input  wire logic                                   byte_valid,
	input  wire logic                                   invert_mirroring,
	input  wire logic [7:0]                             byte_data,
	// Cartridge memory
	output nes_host_pkg::mem_write_t                    mem_write,
	output logic                                        mem_we,
	output logic                                        busy,
	output logic                                        done,
	output logic                                        error,
	output nes_host_pkg::mapper_flags_t                 mapper_flags,
	// Controllers
	input  wire logic [`NES_NUM_JOY-1:0][`NES_PAD_BITS-1:0] joy,
	input  nes_host_pkg::pad_options_t                  pad_opts,
	input  wire logic                                   joypad_strobe,
	input  wire logic [`NES_NUM_PORTS-1:0]              joypad_clock,
	output logic [`NES_NUM_PORTS-1:0]                   joypad_data
);

	nes_host_pkg::pad_load_t pad_load;

	rom_loader u_loader (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.downloading      (downloading),
		.byte_valid       (byte_valid),
		.invert_mirroring (invert_mirroring),
		.byte_data        (byte_data),
		.mem_we           (mem_we),
		.mem_write        (mem_write),
		.busy             (busy),
		.done             (done),
		.error            (error),
		.mapper_flags     (mapper_flags)
	);

	pad_port_mapper u_mapper (
		.joy      (joy),
		.pad_opts (pad_opts),
		.load     (pad_load)
	);

	// One shifter per console port
	for (genvar i = 0; i < `NES_NUM_PORTS; i++) begin : g_port
		pad_port_shifter u_shifter (
			.clk        (clk),
			.reset_nes  (reset_nes),
			.strobe     (joypad_strobe),
			.port_clock (joypad_clock[i]),
			.load_word  (pad_load.word[i]),
			.serial_out (joypad_data[i])
		);
	end

endmodule

`default_nettype wire

/* verification/nes_host_props.sv */
// Protocol assertions on the top-level outputs of the NES host glue
// Attached to nes_host with a bind statement from the testbench
`timescale 1ns/1ps
`default_nettype none

`include "nes_host_defines.svh"

module nes_host_props (
	input wire logic                        clk,
	input wire logic                        reset_nes,
	input wire logic                        mem_we,
	input wire logic                        busy,
	input wire logic                        done,
	input wire logic                        error,
	input wire logic [`NES_NUM_PORTS-1:0]   joypad_data
);

	a_done_not_busy: assert property (@(posedge clk) disable iff (reset_nes)
		!(done && busy))
		else $error("done and busy are high together");

	a_error_done: assert property (@(posedge clk) disable iff (reset_nes)
		error |-> done)
		else $error("error is high without done");

	a_we_busy: assert property (@(posedge clk) disable iff (reset_nes)
		mem_we |-> busy)
		else $error("mem_we is high while the loader is not busy");

	// Everything idle right after reset drops
	a_reset_idle: assert property (@(posedge clk)
		$fell(reset_nes) |-> !mem_we && !busy && !done && !error && joypad_data == '0)
		else $error("control outputs not cleared after reset");

endmodule

`default_nettype wire

/* verification/tb_nes_host.sv */
// Testbench for the NES host glue with iNES loads and controller port readout
// Stimulus on the falling edge and checking by concurrent assertions
`timescale 1ns/1ps
`default_nettype none

`include "nes_host_defines.svh"

module tb_nes_host;

	// One byte per cycle for the 1+1 page image plus margin for short loads and pads
	localparam int MAX_CYCLES = 16 + 16384 + 8192 + 1000;

	logic clk, reset_nes, downloading, byte_valid, invert_mirroring, joypad_strobe;
	logic [7:0] byte_data;
	logic [`NES_NUM_JOY-1:0][`NES_PAD_BITS-1:0] joy;
	logic [`NES_NUM_PORTS-1:0] joypad_clock, joypad_data;
	nes_host_pkg::pad_options_t pad_opts;
	nes_host_pkg::mem_write_t mem_write;
	nes_host_pkg::mapper_flags_t mapper_flags, exp_flags;
	logic mem_we, busy, done, error;
	logic exp_we, end_check, exp_error, pad_check;
	logic [`NES_ADDR_W-1:0] exp_addr;
	logic [7:0] exp_data;
	logic [`NES_NUM_PORTS-1:0] exp_pad;
	logic [7:0] hdr [`NES_HDR_BYTES];
	int seed = 91548;
	int cycles = 0;

	nes_host DUT (.*);

	bind nes_host nes_host_props u_props (.clk(clk), .reset_nes(reset_nes), .mem_we(mem_we),
		.busy(busy), .done(done), .error(error), .joypad_data(joypad_data));

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic stop_on_failure();
		$display("Checks failed");
		$fatal(1);
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == MAX_CYCLES) begin
			$display("Timeout: the run went past %0d cycles", MAX_CYCLES);
			stop_on_failure();
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	a_we: assert property (@(posedge clk) disable iff (reset_nes) mem_we == exp_we)
		else begin
			$display("error at %0t: mem_we expected %0b got %0b", $time, exp_we, mem_we);
			stop_on_failure();
		end
	a_addr: assert property (@(posedge clk) disable iff (reset_nes)
		mem_we |-> mem_write.addr == exp_addr)
		else begin
			$display("error at %0t: mem_write.addr expected %h got %h", $time,
				exp_addr, mem_write.addr);
			stop_on_failure();
		end
	a_data: assert property (@(posedge clk) disable iff (reset_nes)
		mem_we |-> mem_write.data == exp_data)
		else begin
			$display("error at %0t: mem_write.data expected %h got %h", $time,
				exp_data, mem_write.data);
			stop_on_failure();
		end
	a_end: assert property (@(posedge clk) disable iff (reset_nes)
		end_check |-> done && error == exp_error)
		else begin
			$display("error at %0t: error expected %0b got %0b (done %0b)", $time,
				exp_error, error, done);
			stop_on_failure();
		end
	a_flags: assert property (@(posedge clk) disable iff (reset_nes)
		end_check && !exp_error |-> mapper_flags == exp_flags)
		else begin
			$display("error at %0t: mapper_flags expected %h got %h", $time,
				exp_flags, mapper_flags);
			stop_on_failure();
		end
	a_pad: assert property (@(posedge clk) disable iff (reset_nes)
		pad_check |-> joypad_data == exp_pad)
		else begin
			$display("error at %0t: joypad_data expected %b got %b", $time,
				exp_pad, joypad_data);
			stop_on_failure();
		end

	//////////////////////////////////////////////////////////////////////
	// Reference rules
	//////////////////////////////////////////////////////////////////////

	function automatic logic [7:0] fill_byte(input logic [`NES_ADDR_W-1:0] a);
		return a[7:0] ^ a[15:8] ^ {2'b00, a[21:16]} ^ 8'h5A;
	endfunction

	function automatic logic [2:0] pages_to_code(input logic [7:0] pages);
		int code;
		code = 0;
		while (code < 7 && (1 << code) < pages)
			code++;
		return 3'(code);
	endfunction

	function automatic nes_host_pkg::mapper_flags_t header_rule(input logic inv);
		nes_host_pkg::mapper_flags_t f;
		logic v2;
		logic dirty;
		v2    = hdr[7][3] && !hdr[7][2];
		dirty = hdr[9] > 8'd1;
		for (int i = 10; i < `NES_HDR_BYTES; i++)
			dirty = dirty || hdr[i] != 8'd0;
		dirty         = dirty && !v2;
		f             = '0;
		f.has_saves   = hdr[6][1];
		f.submapper   = v2 ? hdr[8] : 8'd0;
		f.four_screen = hdr[6][3];
		f.chr_ram     = hdr[5] == 8'd0;
		f.mirroring   = inv ? !hdr[6][0] : hdr[6][0];
		f.chr_size    = pages_to_code(hdr[5]);
		f.prg_size    = pages_to_code(hdr[4]);
		f.mapper      = {hdr[7][7:4] & {4{!dirty}}, hdr[6][7:4]};
		return f;
	endfunction

	// Shift order A B Select Start Up Down Left Right from host R L D U A B Sel St
	function automatic logic [7:0] nes_buttons(input logic [7:0] host);
		logic [7:0] b;
		b[0] = host[4];
		b[1] = host[5];
		b[2] = host[6];
		b[3] = host[7];
		b[4] = host[3];
		b[5] = host[2];
		b[6] = host[1];
		b[7] = host[0];
		return b;
	endfunction

	function automatic logic [23:0] port_word(input int p);
		logic [7:0] upper;
		logic [7:0] middle;
		int player;
		player = pad_opts.swap ? 1 - p : p;
		upper  = 8'hFF;
		middle = 8'hFF;
		if (pad_opts.multitap) begin
			middle = nes_buttons(joy[p + 2]);
			upper  = (p == 0) ? `NES_TAP_SIG_0 : `NES_TAP_SIG_1;
		end
		return {upper, middle, nes_buttons(joy[player])};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	task automatic base_header(input logic [7:0] prg, chr, b6, b7);
		for (int i = 0; i < `NES_HDR_BYTES; i++)
			hdr[i] = 8'h00;
		hdr[0] = `NES_MAGIC_0;
		hdr[1] = `NES_MAGIC_1;
		hdr[2] = `NES_MAGIC_2;
		hdr[3] = `NES_MAGIC_3;
		hdr[4] = prg;
		hdr[5] = chr;
		hdr[6] = b6;
		hdr[7] = b7;
	endtask

	task automatic send_byte(input logic [7:0] d, input logic we,
		input logic [`NES_ADDR_W-1:0] a);
		byte_valid = 1'b1;
		byte_data  = d;
		exp_we     = we;
		exp_addr   = a;
		exp_data   = d;
		@(negedge clk);
	endtask

	task automatic load_image(input logic good);
		int prg_n;
		int chr_n;
		prg_n = hdr[4] * 16384;
		chr_n = hdr[5] * 8192;
		downloading = 1'b0;
		@(negedge clk);
		downloading = 1'b1;                      // Rising edge restarts the loader
		@(negedge clk);
		for (int i = 0; i < `NES_HDR_BYTES; i++)
			send_byte(hdr[i], 1'b0, '0);
		if (good) begin
			for (int k = 0; k < prg_n; k++)
				send_byte(fill_byte(22'(k)), 1'b1, 22'(k));
			byte_valid = 1'b0;
			exp_we     = 1'b0;
			@(negedge clk);                      // Region switch
			for (int k = 0; k < chr_n; k++)
				send_byte(fill_byte(`NES_CHR_BASE + 22'(k)), 1'b1, `NES_CHR_BASE + 22'(k));
		end else begin
			for (int k = 0; k < 32; k++)
				send_byte(8'(k), 1'b0, '0);      // Must be dropped
		end
		byte_valid = 1'b0;
		exp_we     = 1'b0;
		while (!done)
			@(negedge clk);
		exp_error = !good;
		exp_flags = header_rule(invert_mirroring);
		end_check = 1'b1;
		@(negedge clk);
		end_check = 1'b0;
	endtask

	task automatic read_pads(input logic swap, input logic multitap);
		logic [23:0] w0;
		logic [23:0] w1;
		for (int j = 0; j < `NES_NUM_JOY; j++)
			joy[j] = 8'($random(seed));
		pad_opts.swap     = swap;
		pad_opts.multitap = multitap;
		w0 = port_word(0);
		w1 = port_word(1);
		joypad_strobe = 1'b1;
		@(negedge clk);
		joypad_strobe = 1'b0;
		for (int i = 0; i < 26; i++) begin
			exp_pad[0]   = (i < 24) ? w0[i] : 1'b0;  // Zeros after the last bit
			exp_pad[1]   = (i < 24) ? w1[i] : 1'b0;
			pad_check    = 1'b1;
			joypad_clock = 2'b11;
			@(negedge clk);
			joypad_clock = 2'b00;
			@(negedge clk);
		end
		pad_check = 1'b0;
	endtask

	initial begin
		reset_nes        = 1'b1;
		downloading      = 1'b0;
		byte_valid       = 1'b0;
		byte_data        = 8'h00;
		invert_mirroring = 1'b0;
		joy              = '0;
		pad_opts         = '0;
		joypad_strobe    = 1'b0;
		joypad_clock     = '0;
		exp_we           = 1'b0;
		exp_addr         = '0;
		exp_data         = 8'h00;
		exp_error        = 1'b0;
		exp_flags        = '0;
		exp_pad          = '0;
		end_check        = 1'b0;
		pad_check        = 1'b0;
		repeat (3) @(negedge clk);
		reset_nes = 1'b0;

		base_header(8'd1, 8'd1, 8'h41, 8'h00);   // Mapper 4 with vertical mirroring
		invert_mirroring = 1'b1;
		load_image(1'b1);
		invert_mirroring = 1'b0;

		base_header(8'd1, 8'd1, 8'h41, 8'h00);
		hdr[3] = 8'h1B;                          // Broken magic
		load_image(1'b0);

		base_header(8'd1, 8'd1, 8'h45, 8'h00);   // Trainer present
		load_image(1'b0);

		base_header(8'd0, 8'd0, 8'h1A, 8'h28);   // iNES 2.0 with four screen
		hdr[8]  = 8'h35;
		hdr[10] = 8'h01;                         // Tail bytes are legal in 2.0
		load_image(1'b1);

		base_header(8'd0, 8'd0, 8'h11, 8'hA0);   // Junk in a 1.0 header
		hdr[8]  = 8'h07;                         // No submapper outside 2.0
		hdr[9]  = 8'h02;
		hdr[12] = 8'h55;
		load_image(1'b1);

		read_pads(1'b0, 1'b0);
		read_pads(1'b1, 1'b1);

		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

/* nes_host.f */
+incdir+include
hw/nes_host_pkg.sv
hw/ines_header_decoder.sv
hw/rom_loader.sv
hw/pad_port_mapper.sv
hw/pad_port_shifter.sv
hw/nes_host.sv
verification/nes_host_props.sv
verification/tb_nes_host.sv

/* run_sim.sh */
#!/bin/sh
# Builds the NES host testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f nes_host.f \
	--top-module tb_nes_host -o tb_nes_host
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/tb_nes_host 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -q "All checks passed"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1
